/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// bus widths
	localparam int addr_width = 32;
	localparam int data_width = 32;

	// led peripheral size
	localparam int led_count = 4;

	// slot field sits at addr[13:12], four slots
	localparam int slot_lsb  = 12;
	localparam int slot_bits = 2;

	// slot 0 is the led driver, the rest are empty
	localparam logic [slot_bits-1:0] led_slot = 2'd0;

	// register offsets inside a slot
	localparam logic [slot_lsb-1:0] reg_led_out   = 12'h000;
	localparam logic [slot_lsb-1:0] reg_led_blink = 12'h004;
	// read-only, returns current pins
	localparam logic [slot_lsb-1:0] reg_led_pins  = 12'h008;

	// clock cycles per blink phase
	localparam int blink_half     = 16;
	localparam int blink_cnt_bits = $clog2(blink_half);

	// host operation
	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} host_op_t;

	// apb master states
	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_setup  = 2'd1,
		st_access = 2'd2
	} apb_state_t;

endpackage

`default_nettype wire

/* hdl/apb_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_bridge (
	input  logic                            clk,
	input  logic                            reset,
	// host request, one-cycle strobe
	input  logic                            req_valid,
	input  soc_pkg::host_op_t               req_op,
	input  logic [soc_pkg::addr_width-1:0]  req_addr,
	input  logic [soc_pkg::data_width-1:0]  req_wdata,
	// apb master
	output logic                            psel,
	output logic                            penable,
	output logic                            pwrite,
	output logic [soc_pkg::addr_width-1:0]  paddr,
	output logic [soc_pkg::data_width-1:0]  pwdata,
	input  logic [soc_pkg::data_width-1:0]  prdata,
	input  logic                            pready,
	input  logic                            pslverr,
	// host response, one-cycle strobe
	output logic                            resp_valid,
	output logic [soc_pkg::data_width-1:0]  resp_rdata,
	output logic                            resp_err
);
	import soc_pkg::*;

	apb_state_t state;
	apb_state_t state_next;
	logic       start;
	logic       done;

	// new request only taken in idle
	assign start = (state == st_idle) && req_valid;
	// transfer completes on this edge
	assign done = (state == st_access) && pready;

	// bus control straight from state
	assign psel    = (state != st_idle);
	assign penable = (state == st_access);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (req_valid) begin
					state_next = st_setup;
				end
			end
			// setup is always a single cycle
			st_setup: begin
				state_next = st_access;
			end
			// stay in access until slave is ready
			st_access: begin
				if (pready) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	// capture request, held stable for the whole transfer
	always_ff @(posedge clk) begin
		if (start) begin
			paddr  <= req_addr;
			pwdata <= req_wdata;
			pwrite <= (req_op == op_write);
		end
	end

	// response strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= done;
		end
	end

	// response payload, zero read data on writes
	always_ff @(posedge clk) begin
		if (done) begin
			resp_rdata <= pwrite ? '0 : prdata;
			resp_err   <= pslverr;
		end
	end

endmodule

`default_nettype wire

/* hdl/apb_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_mux (
	// from bridge
	input  logic                            psel,
	input  logic                            penable,
	input  logic [soc_pkg::addr_width-1:0]  paddr,
	// back to bridge
	output logic [soc_pkg::data_width-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr,
	// led driver slot
	output logic                            led_psel,
	input  logic [soc_pkg::data_width-1:0]  led_prdata,
	input  logic                            led_pready
);
	import soc_pkg::*;

	logic [slot_bits-1:0] slot;
	logic                 led_hit;
	logic                 empty_access;

	// slot field from address
	assign slot = paddr[slot_lsb +: slot_bits];

	assign led_hit = (slot == led_slot);

	// select only reaches the led driver for its own slot
	assign led_psel = psel & led_hit;

	// empty slots complete in their first access cycle
	assign empty_access = psel & penable & ~led_hit;

	// return path
	always_comb begin
		if (led_hit) begin
			prdata  = led_prdata;
			pready  = led_pready;
			pslverr = 1'b0;
		end else begin
			// nothing behind slots 1..3, error with zero data
			prdata  = '0;
			pready  = empty_access;
			pslverr = empty_access;
		end
	end

endmodule

`default_nettype wire

/* hdl/led_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module led_driver (
	input  logic                            clk,
	input  logic                            reset,
	// apb slave
	input  logic                            led_psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [soc_pkg::addr_width-1:0]  paddr,
	input  logic [soc_pkg::data_width-1:0]  pwdata,
	output logic [soc_pkg::data_width-1:0]  led_prdata,
	output logic                            led_pready,
	// pins
	output logic [soc_pkg::led_count-1:0]   led
);
	import soc_pkg::*;

	logic [slot_lsb-1:0]       offset;
	logic                      wr_en;
	logic [led_count-1:0]      out_reg;
	logic [led_count-1:0]      blink_mask;
	logic [blink_cnt_bits-1:0] blink_cnt;
	logic                      blink_phase;

	// register offset within the slot
	assign offset = paddr[slot_lsb-1:0];

	// no wait states
	assign led_pready = led_psel & penable;

	// write lands on the completing edge
	assign wr_en = led_psel & penable & pwrite;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_reg    <= '0;
			blink_mask <= '0;
		end else if (wr_en) begin
			case (offset)
				reg_led_out:   out_reg    <= pwdata[led_count-1:0];
				reg_led_blink: blink_mask <= pwdata[led_count-1:0];
				// pins register and unused offsets ignore writes
				default: ;
			endcase
		end
	end

	// free-running blink timer
	always_ff @(posedge clk) begin
		if (reset) begin
			blink_cnt   <= '0;
			blink_phase <= 1'b0;
		end else if (blink_cnt == blink_cnt_bits'(blink_half - 1)) begin
			blink_cnt   <= '0;
			blink_phase <= ~blink_phase;
		end else begin
			blink_cnt <= blink_cnt + 1'b1;
		end
	end

	// pins registered, masked bits flip in the set phase
	always_ff @(posedge clk) begin
		if (reset) begin
			led <= '0;
		end else begin
			led <= out_reg ^ (blink_phase ? blink_mask : '0);
		end
	end

	// readback, unused offsets read zero
	always_comb begin
		led_prdata = '0;
		case (offset)
			reg_led_out:   led_prdata[led_count-1:0] = out_reg;
			reg_led_blink: led_prdata[led_count-1:0] = blink_mask;
			reg_led_pins:  led_prdata[led_count-1:0] = led;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/led_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module led_soc_top (
	input  logic                            clk,
	input  logic                            reset,
	// host request
	input  logic                            req_valid,
	input  soc_pkg::host_op_t               req_op,
	input  logic [soc_pkg::addr_width-1:0]  req_addr,
	input  logic [soc_pkg::data_width-1:0]  req_wdata,
	// host response
	output logic                            resp_valid,
	output logic [soc_pkg::data_width-1:0]  resp_rdata,
	output logic                            resp_err,
	// led pins
	output logic [soc_pkg::led_count-1:0]   led
);
	import soc_pkg::*;

	// apb master bus
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [addr_width-1:0] paddr;
	logic [data_width-1:0] pwdata;
	logic [data_width-1:0] prdata;
	logic                  pready;
	logic                  pslverr;

	// slot 0
	logic                  led_psel;
	logic [data_width-1:0] led_prdata;
	logic                  led_pready;

	apb_bridge bridge0 (
		.clk        (clk        ),
		.reset      (reset      ),
		.req_valid  (req_valid  ),
		.req_op     (req_op     ),
		.req_addr   (req_addr   ),
		.req_wdata  (req_wdata  ),
		.psel       (psel       ),
		.penable    (penable    ),
		.pwrite     (pwrite     ),
		.paddr      (paddr      ),
		.pwdata     (pwdata     ),
		.prdata     (prdata     ),
		.pready     (pready     ),
		.pslverr    (pslverr    ),
		.resp_valid (resp_valid ),
		.resp_rdata (resp_rdata ),
		.resp_err   (resp_err   )
	);

	// slot decode, empty slots answered here
	apb_mux mux0 (
		.psel       (psel       ),
		.penable    (penable    ),
		.paddr      (paddr      ),
		.prdata     (prdata     ),
		.pready     (pready     ),
		.pslverr    (pslverr    ),
		.led_psel   (led_psel   ),
		.led_prdata (led_prdata ),
		.led_pready (led_pready )
	);

	led_driver led0 (
		.clk        (clk        ),
		.reset      (reset      ),
		.led_psel   (led_psel   ),
		.penable    (penable    ),
		.pwrite     (pwrite     ),
		.paddr      (paddr      ),
		.pwdata     (pwdata     ),
		.led_prdata (led_prdata ),
		.led_pready (led_pready ),
		.led        (led        )
	);

endmodule

`default_nettype wire

/* test/led_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module led_soc_tb;
	import soc_pkg::*;

	logic                  clk;
	logic                  reset;
	logic                  req_valid;
	host_op_t              req_op;
	logic [addr_width-1:0] req_addr;
	logic [data_width-1:0] req_wdata;
	logic                  resp_valid;
	logic [data_width-1:0] resp_rdata;
	logic                  resp_err;
	logic [led_count-1:0]  led;

	// case table from the data file
	logic                  q_op[$];
	logic [addr_width-1:0] q_addr[$];
	logic [data_width-1:0] q_wdata[$];
	logic [data_width-1:0] q_rdata[$];
	logic                  q_err[$];
	logic                  cases_loaded;
	// high while a request waits for its response
	logic                  expect_resp;

	led_soc_top dut0 (
		.clk        (clk        ),
		.reset      (reset      ),
		.req_valid  (req_valid  ),
		.req_op     (req_op     ),
		.req_addr   (req_addr   ),
		.req_wdata  (req_wdata  ),
		.resp_valid (resp_valid ),
		.resp_rdata (resp_rdata ),
		.resp_err   (resp_err   ),
		.led        (led        )
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s (actual %0h, expected %0h)",
				$time, msg, actual, expected);
			$display("Something failed");
			$fatal(1, "stopping after a value mismatch");
		end
	endtask

	// case file columns are op addr wdata exp_rdata exp_err
	// lines starting with # are comments
	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_wdata;
		logic [31:0] f_rdata;
		logic [31:0] f_err;
		fd = $fopen("test/led_soc_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file test/led_soc_cases.txt");
			$display("Something failed");
			$fatal(1, "no case file");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() == 0 || line[0] == "#") continue;
			n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_wdata, f_rdata, f_err);
			if (n != 5 && line.len() > 1) begin
				$display("malformed line in the case file: %s", line);
				$display("Something failed");
				$fatal(1, "bad case file");
			end
			if (n == 5) begin
				q_op.push_back(f_op[0]);
				q_addr.push_back(f_addr);
				q_wdata.push_back(f_wdata);
				q_rdata.push_back(f_rdata);
				q_err.push_back(f_err[0]);
			end
		end
		$fclose(fd);
	endtask

	// one request strobe that starts and ends 1 ns after a rising edge
	task automatic send(input logic op, input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waited;
		req_valid   = 1'b1;
		req_op      = host_op_t'(op);
		req_addr    = addr;
		req_wdata   = wdata;
		expect_resp = 1'b1;
		// this edge samples the strobe
		@(posedge clk);
		#1;
		req_valid = 1'b0;
		waited    = 0;
		while (resp_valid !== 1'b1 && waited < 8) begin
			@(posedge clk);
			#1;
			waited++;
		end
		check(32'(waited), 32'd2, "edges from request to resp_valid");
		rdata = resp_rdata;
		err   = resp_err;
		@(posedge clk);
		#1;
		check(32'(resp_valid), 32'd0, "resp_valid wider than one cycle");
		expect_resp = 1'b0;
	endtask

	// no response without an outstanding request
	always @(negedge clk) begin
		if (!reset && !expect_resp) begin
			check(32'(resp_valid), 32'd0, "resp_valid without a request");
		end
	end

	// bounded by the case count plus the blink window
	initial begin
		wait (cases_loaded);
		repeat (q_op.size() * 20 + 200) @(posedge clk);
		$display("timeout, the test did not finish in time");
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0]          rdata;
		logic                 err;
		logic [led_count-1:0] model_out;
		logic [led_count-1:0] model_mask;
		logic                 seen_p;
		logic                 seen_x;
		int                   idle;
		reset        = 1'b1;
		req_valid    = 1'b0;
		req_op       = op_read;
		req_addr     = '0;
		req_wdata    = '0;
		expect_resp  = 1'b0;
		cases_loaded = 1'b0;
		model_out    = '0;
		model_mask   = '0;
		seen_p       = 1'b0;
		seen_x       = 1'b0;
		void'($urandom(32'hcb895b89));
		load_cases();
		cases_loaded = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		check(32'(led), 32'd0, "led after reset");

		for (int i = 0; i < q_op.size(); i++) begin
			idle = int'($urandom % 4);
			repeat (idle) begin
				@(posedge clk);
				#1;
			end
			send(q_op[i], q_addr[i], q_wdata[i], rdata, err);
			check(rdata, q_rdata[i], $sformatf("read data of case %0d", i));
			check(32'(err), 32'(q_err[i]), $sformatf("error flag of case %0d", i));
			// only slot 0 writes at the two writable offsets land
			if (q_op[i] && q_addr[i][slot_lsb +: slot_bits] == led_slot) begin
				if (q_addr[i][slot_lsb-1:0] == reg_led_out)
					model_out = q_wdata[i][led_count-1:0];
				if (q_addr[i][slot_lsb-1:0] == reg_led_blink)
					model_mask = q_wdata[i][led_count-1:0];
			end
			if (model_mask == '0) begin
				check(32'(led), 32'(model_out), $sformatf("led after case %0d", i));
			end
		end

		// blink window uses the last output and mask from the cases
		if (model_mask == '0) begin
			$display("the case file leaves the blink mask at zero, blink cannot be checked");
			$display("Something failed");
			$fatal(1, "no blink mask");
		end
		repeat (4 * blink_half) begin
			@(posedge clk);
			#1;
			check(32'(led == model_out || led == (model_out ^ model_mask)), 32'd1,
				"led outside the blink pair");
			if (led == model_out) seen_p = 1'b1;
			if (led == (model_out ^ model_mask)) seen_x = 1'b1;
		end
		check(32'(seen_p), 32'd1, "steady blink phase never seen");
		check(32'(seen_x), 32'd1, "flipped blink phase never seen");
		repeat (3) begin
			send(1'b0, 32'(reg_led_pins), 32'd0, rdata, err);
			check(32'(rdata == 32'(model_out) || rdata == 32'(model_out ^ model_mask)), 32'd1,
				"pin readback outside the blink pair");
			check(32'(err), 32'd0, "error flag on pin readback");
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* test/led_soc_cases.txt */
# op addr wdata exp_rdata exp_err, all hex
# op 0 is a read and 1 a write, slot is addr[13:12], writes expect read data 0
0 00000000 00000000 00000000 0
0 00000004 00000000 00000000 0
0 00000008 00000000 00000000 0
1 00000000 0000000a 00000000 0
0 00000000 00000000 0000000a 0
0 00000008 00000000 0000000a 0
1 00000000 ffffff35 00000000 0
0 00000000 00000000 00000005 0
1 00000008 0000000f 00000000 0
0 00000008 00000000 00000005 0
0 00000000 00000000 00000005 0
1 00000004 000000f0 00000000 0
0 00000004 00000000 00000000 0
0 0000000c 00000000 00000000 0
1 00001000 0000000f 00000000 1
0 00001000 00000000 00000000 1
1 00002004 0000000c 00000000 1
0 00002004 00000000 00000000 1
1 00003000 00000003 00000000 1
0 00003008 00000000 00000000 1
0 00000000 00000000 00000005 0
0 00000004 00000000 00000000 0
1 00000000 00000006 00000000 0
1 00000004 00000009 00000000 0
0 00000004 00000000 00000009 0

/* led_soc_top.f */
hdl/soc_pkg.sv
hdl/apb_bridge.sv
hdl/apb_mux.sv
hdl/led_driver.sv
hdl/led_soc_top.sv
test/led_soc_tb.sv

/* run.sh */
#!/bin/sh
# build and run the LED SoC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module led_soc_tb \
	-f led_soc_top.f \
	-o led_soc_sim

# the simulator exits nonzero on any failing check or timeout
./obj_dir/led_soc_sim
